// File: fe_pkg.sv
package fe_pkg;

  localparam int XLEN      = 32;
  localparam int INST_LEN  = 32;
  localparam int RAM_DEPTH = 256;
  localparam int RAM_IDX_W = $clog2(RAM_DEPTH);
  // byte size of the instruction RAM, fetches at or above this trap
  localparam int RAM_BYTES = RAM_DEPTH * 4;
  localparam int NSTAGE    = 6;

  // stage indices into the stall and flush vectors
  localparam int CTRL_IF     = 0;
  localparam int CTRL_IF_ID  = 1;
  localparam int CTRL_ID_EX  = 2;
  localparam int CTRL_EX_MEM = 3;
  localparam int CTRL_MEM_WB = 4;
  localparam int CTRL_WB     = 5;

  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [INST_LEN-1:0]  inst_t;
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;
  // bit 0 misaligned fetch, bit 1 fetch beyond the RAM
  typedef logic [1:0]           trap_t;
  typedef logic [NSTAGE-1:0]    ctrl_vec_t;

  localparam addr_t PC_RESET_ADDR = 32'h0000_0100;
  // IF shows this address when it holds no instruction
  localparam addr_t PC_IDLE_ADDR  = PC_RESET_ADDR - 32'd4;
  localparam inst_t INST_NOP      = 32'h0000_0013;

  typedef struct packed {
    addr_t addr;
    inst_t inst;
    logic  bpu_taken;
    trap_t trap;
  } if_bundle_t;

  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic     en;
    logic     we;
    ram_idx_t idx;
    inst_t    wdata;
  } ram_req_t;

  localparam if_bundle_t IF_ID_RESET = '{addr: '0, inst: INST_NOP, bpu_taken: 1'b0, trap: '0};

endpackage

// File: inst_ram.sv
`timescale 1ns/1ps

module inst_ram
  import fe_pkg::*;
(
  input  logic     clk,
  input  ram_req_t req_i,
  output inst_t    rdata_o
);

  inst_t mem [RAM_DEPTH];

  // a write leaves the read port alone, so rdata_o holds the last word read
  always_ff @(posedge clk) begin
    if (req_i.en) begin
      if (req_i.we) begin
        mem[req_i.idx] <= req_i.wdata;
      end else begin
        rdata_o <= mem[req_i.idx];
      end
    end
  end

endmodule

// File: imem_arbiter.sv
`timescale 1ns/1ps

module imem_arbiter
  import fe_pkg::*;
(
  input  logic     fetch_req_i,
  input  ram_idx_t fetch_idx_i,
  input  logic     load_we_i,
  input  ram_idx_t load_addr_i,
  input  inst_t    load_data_i,
  output ram_req_t ram_req_o,
  output logic     fetch_gnt_o
);

  // load port has fixed priority over fetch
  assign fetch_gnt_o = fetch_req_i & ~load_we_i;

  always_comb begin
    ram_req_o.en = load_we_i | fetch_req_i;
    ram_req_o.we = load_we_i;
    if (load_we_i) begin
      ram_req_o.idx   = load_addr_i;
      ram_req_o.wdata = load_data_i;
    end else begin
      ram_req_o.idx   = fetch_idx_i;
      ram_req_o.wdata = '0;
    end
  end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
  import fe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  ctrl_vec_t  stall_vec_i,
  input  redirect_t  redirect_i,
  input  logic       fetch_gnt_i,
  input  inst_t      rdata_i,
  output logic       fetch_req_o,
  output ram_idx_t   fetch_idx_o,
  output if_bundle_t if_data_o
);

  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  addr_t pc_q;
  addr_t resp_addr_q;
  logic  resp_vld_q;
  trap_t trap_q;
  logic  trap_vld_q;
  logic  stall_if;
  logic  misaligned;
  logic  out_of_range;
  logic  trap_now;
  logic  predict_taken;
  addr_t b_imm;
  addr_t j_imm;
  addr_t pred_target;

  assign stall_if     = stall_vec_i[CTRL_IF];
  assign misaligned   = pc_q[1:0] != 2'b00;
  assign out_of_range = pc_q >= addr_t'(RAM_BYTES);

  assign fetch_req_o = ~stall_if & ~misaligned & ~out_of_range & ~redirect_i.valid;
  assign fetch_idx_o = pc_q[RAM_IDX_W+1:2];

  // static prediction on the word returned this cycle
  assign b_imm = {{20{rdata_i[31]}}, rdata_i[7], rdata_i[30:25], rdata_i[11:8], 1'b0};
  assign j_imm = {{12{rdata_i[31]}}, rdata_i[19:12], rdata_i[20], rdata_i[30:21], 1'b0};
  assign predict_taken = resp_vld_q & ((rdata_i[6:0] == OPC_JAL) |
                                       ((rdata_i[6:0] == OPC_BRANCH) & rdata_i[31]));
  assign pred_target = resp_addr_q + ((rdata_i[6:0] == OPC_JAL) ? j_imm : b_imm);

  // report a bad PC once, then park until a redirect
  assign trap_now = ~predict_taken & (misaligned | out_of_range) & (trap_q == '0);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q       <= PC_RESET_ADDR;
      resp_vld_q <= 1'b0;
      trap_q     <= '0;
      trap_vld_q <= 1'b0;
    end else if (redirect_i.valid) begin
      pc_q       <= redirect_i.target;
      resp_vld_q <= 1'b0;
      trap_q     <= '0;
      trap_vld_q <= 1'b0;
    end else if (!stall_if) begin
      trap_vld_q <= trap_now;
      if (trap_now) begin
        trap_q <= {out_of_range, misaligned};
      end
      // taken prediction drops the sequential word behind it
      resp_vld_q <= fetch_gnt_i & ~predict_taken;
      if (predict_taken) begin
        pc_q <= pred_target;
      end else if (fetch_gnt_i) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_gnt_i && !stall_if) begin
      resp_addr_q <= pc_q;
    end
  end

  always_comb begin
    if (trap_vld_q) begin
      if_data_o = '{addr: pc_q, inst: INST_NOP, bpu_taken: 1'b0, trap: trap_q};
    end else if (resp_vld_q) begin
      if_data_o = '{addr: resp_addr_q, inst: rdata_i, bpu_taken: predict_taken, trap: '0};
    end else begin
      if_data_o = '{addr: PC_IDLE_ADDR, inst: INST_NOP, bpu_taken: 1'b0, trap: '0};
    end
  end

endmodule

// File: pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl
  import fe_pkg::*;
(
  input  logic      stall_id_i,
  input  logic      redirect_valid_i,
  output ctrl_vec_t stall_vec_o,
  output ctrl_vec_t flush_vec_o
);

  always_comb begin
    stall_vec_o = '0;
    flush_vec_o = '0;

    // decode back-pressure freezes fetch and IF/ID, ID_EX bit tells the core
    if (stall_id_i) begin
      stall_vec_o[CTRL_IF]    = 1'b1;
      stall_vec_o[CTRL_IF_ID] = 1'b1;
      stall_vec_o[CTRL_ID_EX] = 1'b1;
    end

    // wrong-path work sits in IF/ID and decode
    if (redirect_valid_i) begin
      flush_vec_o[CTRL_IF_ID] = 1'b1;
      flush_vec_o[CTRL_ID_EX] = 1'b1;
    end
  end

endmodule

// File: if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg
  import fe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  ctrl_vec_t  stall_vec_i,
  input  ctrl_vec_t  flush_vec_i,
  input  if_bundle_t if_data_i,
  output if_bundle_t if_id_o
);

  logic hold;
  logic idle;
  logic flush;

  assign hold = stall_vec_i[CTRL_IF_ID];
  assign idle = if_data_i.addr == PC_IDLE_ADDR;

  // an empty IF cycle enters decode as a NOP, but never breaks a hold
  assign flush = flush_vec_i[CTRL_IF_ID] | (idle & ~hold);

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      if_id_o.addr      <= IF_ID_RESET.addr;
      if_id_o.inst      <= IF_ID_RESET.inst;
      if_id_o.bpu_taken <= IF_ID_RESET.bpu_taken;
      if_id_o.trap      <= IF_ID_RESET.trap;
    end else if (flush) begin
      if_id_o.addr      <= IF_ID_RESET.addr;
      if_id_o.inst      <= IF_ID_RESET.inst;
      if_id_o.bpu_taken <= IF_ID_RESET.bpu_taken;
      if_id_o.trap      <= IF_ID_RESET.trap;
    end else if (!hold) begin
      if_id_o <= if_data_i;
    end
  end

endmodule

// File: frontend_top.sv
`timescale 1ns/1ps

module frontend_top
  import fe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       load_we_i,
  input  ram_idx_t   load_addr_i,
  input  inst_t      load_data_i,
  input  logic       stall_id_i,
  input  redirect_t  redirect_i,
  output if_bundle_t if_id_o,
  output logic       stall_o,
  output logic       flush_o
);

  logic       fetch_req;
  ram_idx_t   fetch_idx;
  logic       fetch_gnt;
  ram_req_t   ram_req;
  inst_t      ram_rdata;
  if_bundle_t if_data;
  ctrl_vec_t  stall_vec;
  ctrl_vec_t  flush_vec;

  assign stall_o = stall_vec[CTRL_ID_EX];
  assign flush_o = flush_vec[CTRL_ID_EX];

  pipe_ctrl u_pipe_ctrl (
    .stall_id_i      (stall_id_i),
    .redirect_valid_i(redirect_i.valid),
    .stall_vec_o     (stall_vec),
    .flush_vec_o     (flush_vec)
  );

  fetch_unit u_fetch_unit (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stall_vec_i(stall_vec),
    .redirect_i (redirect_i),
    .fetch_gnt_i(fetch_gnt),
    .rdata_i    (ram_rdata),
    .fetch_req_o(fetch_req),
    .fetch_idx_o(fetch_idx),
    .if_data_o  (if_data)
  );

  imem_arbiter u_imem_arbiter (
    .fetch_req_i(fetch_req),
    .fetch_idx_i(fetch_idx),
    .load_we_i  (load_we_i),
    .load_addr_i(load_addr_i),
    .load_data_i(load_data_i),
    .ram_req_o  (ram_req),
    .fetch_gnt_o(fetch_gnt)
  );

  inst_ram u_inst_ram (
    .clk    (clk),
    .req_i  (ram_req),
    .rdata_o(ram_rdata)
  );

  if_id_reg u_if_id_reg (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stall_vec_i(stall_vec),
    .flush_vec_i(flush_vec),
    .if_data_i  (if_data),
    .if_id_o    (if_id_o)
  );

endmodule

// File: frontend_props.sv
`timescale 1ns/1ps

module frontend_props
  import fe_pkg::*;
(
  input logic       clk,
  input logic       rst_n_i,
  input ctrl_vec_t  stall_vec_i,
  input ctrl_vec_t  flush_vec_i,
  input if_bundle_t if_id_i
);

  // a flush still overrides a held stage
  hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      stall_vec_i[CTRL_IF_ID] && !flush_vec_i[CTRL_IF_ID] |=> $stable(if_id_i))
    else $error("if_id_o changed while IF_ID was stalled");

  nop_after_flush: assert property (
    @(posedge clk) disable iff (!rst_n_i)
      flush_vec_i[CTRL_IF_ID] |=> if_id_i.inst == INST_NOP)
    else $error("if_id_o.inst is not a NOP after a flush");

  nop_after_reset: assert property (
    @(posedge clk) $rose(rst_n_i) |->
      (if_id_i.addr == '0) && (if_id_i.inst == INST_NOP) &&
      !if_id_i.bpu_taken && (if_id_i.trap == '0))
    else $error("if_id_o is not the NOP bundle after reset");

endmodule

bind if_id_reg frontend_props u_props (
  .clk        (clk),
  .rst_n_i    (rst_n_i),
  .stall_vec_i(stall_vec_i),
  .flush_vec_i(flush_vec_i),
  .if_id_i    (if_id_o)
);

// File: frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
  import fe_pkg::*;
;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int PROG_WORDS   = 32;

  localparam if_bundle_t NOP_BUNDLE = '{addr: '0, inst: INST_NOP, bpu_taken: 1'b0, trap: 2'b00};

  typedef struct packed {
    logic       we;
    ram_idx_t   widx;
    inst_t      wdata;
    logic       stall;
    logic       rvalid;
    addr_t      tgt;
    if_bundle_t exp_id;
    logic       exp_stall;
    logic       exp_flush;
  } row_t;

  logic       clk;
  logic       rst_n_i;
  logic       load_we_i;
  ram_idx_t   load_addr_i;
  inst_t      load_data_i;
  logic       stall_id_i;
  redirect_t  redirect_i;
  if_bundle_t if_id_o;
  logic       stall_o;
  logic       flush_o;

  // mirror of the instruction RAM contents
  inst_t model [RAM_DEPTH];
  row_t  rows [$];
  logic  table_built = 1'b0;

  frontend_top DUT (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .load_we_i  (load_we_i),
    .load_addr_i(load_addr_i),
    .load_data_i(load_data_i),
    .stall_id_i (stall_id_i),
    .redirect_i (redirect_i),
    .if_id_o    (if_id_o),
    .stall_o    (stall_o),
    .flush_o    (flush_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic ram_idx_t word_index(input addr_t a);
    return a[RAM_IDX_W+1:2];
  endfunction

  function automatic inst_t encode_beq(input int off);
    logic [12:0] imm;
    imm = off[12:0];
    return {imm[12], imm[10:5], 5'd0, 5'd0, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t encode_jal(input int off);
    logic [20:0] imm;
    imm = off[20:0];
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
  endfunction

  function automatic if_bundle_t expect_word(input addr_t a, input logic taken);
    return '{addr: a, inst: model[word_index(a)], bpu_taken: taken, trap: 2'b00};
  endfunction

  // stall_o and flush_o are the ID_EX bits, so they follow stall_id_i and redirect valid
  task automatic add_row(input logic we, input ram_idx_t widx, input inst_t wdata,
                         input logic stall, input logic rvalid, input addr_t tgt,
                         input if_bundle_t exp_id);
    row_t r;
    r = '{we: we, widx: widx, wdata: wdata, stall: stall, rvalid: rvalid, tgt: tgt,
          exp_id: exp_id, exp_stall: stall, exp_flush: rvalid};
    rows.push_back(r);
    if (we) begin
      model[widx] = wdata;
    end
  endtask

  task automatic step_row(input if_bundle_t exp_id);
    add_row(1'b0, '0, '0, 1'b0, 1'b0, '0, exp_id);
  endtask

  task automatic seq_rows(input addr_t first, input int count);
    for (int k = 0; k < count; k++) begin
      step_row(expect_word(first + addr_t'(4 * k), 1'b0));
    end
  endtask

  // predicted-taken word, then the one dropped sequential slot
  task automatic taken_rows(input addr_t a);
    step_row(expect_word(a, 1'b1));
    step_row(NOP_BUNDLE);
  endtask

  task automatic redirect_rows(input addr_t tgt);
    add_row(1'b0, '0, '0, 1'b0, 1'b1, tgt, NOP_BUNDLE);
    step_row(NOP_BUNDLE);
  endtask

  task automatic build_table();
    logic [31:0] w;
    ram_idx_t    idx;
    for (int k = 0; k < PROG_WORDS; k++) begin
      w = $urandom();
      model[word_index(PC_RESET_ADDR) + ram_idx_t'(k)] = {w[31:7], 7'b0010011};
    end
    model[word_index(32'h104)] = encode_beq(8);
    model[word_index(32'h10C)] = encode_jal(20);
    model[word_index(32'h118)] = encode_jal(16);
    model[word_index(32'h124)] = encode_beq(-20);

    for (int k = 0; k < PROG_WORDS; k++) begin
      idx = word_index(PC_RESET_ADDR) + ram_idx_t'(k);
      add_row(1'b1, idx, model[idx], 1'b0, 1'b0, '0, NOP_BUNDLE);
    end
    step_row(NOP_BUNDLE);
    seq_rows(32'h100, 3);
    taken_rows(32'h10C);
    seq_rows(32'h120, 1);
    taken_rows(32'h124);
    seq_rows(32'h110, 2);
    taken_rows(32'h118);
    seq_rows(32'h128, 2);
    repeat (3) add_row(1'b0, '0, '0, 1'b1, 1'b0, '0, expect_word(32'h12C, 1'b0));
    seq_rows(32'h130, 2);
    // load write steals the RAM from the fetch of 0x13c
    idx = word_index(32'h144);
    add_row(1'b1, idx, model[idx] ^ 32'hFFFF_FF80, 1'b0, 1'b0, '0,
            expect_word(32'h138, 1'b0));
    step_row(NOP_BUNDLE);
    seq_rows(32'h13C, 4);
    redirect_rows(32'h150);
    seq_rows(32'h150, 2);
    redirect_rows(32'h102);
    step_row('{addr: 32'h102, inst: INST_NOP, bpu_taken: 1'b0, trap: 2'b01});
    repeat (2) step_row(NOP_BUNDLE);
    redirect_rows(32'h400);
    step_row('{addr: 32'h400, inst: INST_NOP, bpu_taken: 1'b0, trap: 2'b10});
    step_row(NOP_BUNDLE);
    redirect_rows(32'h100);
    seq_rows(32'h100, 2);
  endtask

  task automatic compare(input string name, input logic [95:0] got, input logic [95:0] want);
    if (got !== want) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, want);
      $display("Simulation failed");
      $fatal(1, "check on %s did not match", name);
    end
  endtask

  task automatic drive_row(input row_t r);
    load_we_i   = r.we;
    load_addr_i = r.widx;
    load_data_i = r.wdata;
    stall_id_i  = r.stall;
    redirect_i  = '{valid: r.rvalid, target: r.tgt};
  endtask

  task automatic check_row(input int n, input row_t r);
    compare($sformatf("if_id_o.addr row %0d", n), 96'(if_id_o.addr), 96'(r.exp_id.addr));
    compare($sformatf("if_id_o.inst row %0d", n), 96'(if_id_o.inst), 96'(r.exp_id.inst));
    compare($sformatf("if_id_o.bpu_taken row %0d", n), 96'(if_id_o.bpu_taken),
            96'(r.exp_id.bpu_taken));
    compare($sformatf("if_id_o.trap row %0d", n), 96'(if_id_o.trap), 96'(r.exp_id.trap));
    compare($sformatf("stall_o row %0d", n), 96'(stall_o), 96'(r.exp_stall));
    compare($sformatf("flush_o row %0d", n), 96'(flush_o), 96'(r.exp_flush));
  endtask

  initial begin
    void'($urandom(70));
    rst_n_i     = 1'b0;
    load_we_i   = 1'b0;
    load_addr_i = '0;
    load_data_i = '0;
    stall_id_i  = 1'b0;
    redirect_i  = '0;
    build_table();
    table_built = 1'b1;

    repeat (RESET_CYCLES) @(negedge clk);
    compare("if_id_o after reset", 96'(if_id_o), 96'(NOP_BUNDLE));
    compare("stall_o after reset", 96'(stall_o), 96'(1'b0));
    compare("flush_o after reset", 96'(flush_o), 96'(1'b0));

    // load rows start together with reset release so no fetch reads an empty RAM
    rst_n_i = 1'b1;
    foreach (rows[i]) begin
      drive_row(rows[i]);
      @(negedge clk);
      check_row(i, rows[i]);
    end
    $display("Simulation passed");
    $finish;
  end

  initial begin
    wait (table_built);
    #((RESET_CYCLES + rows.size() + 20) * CLK_PERIOD);
    $display("Simulation failed");
    $fatal(1, "watchdog expired before the table was done");
  end

endmodule

// File: sources.f
fe_pkg.sv
inst_ram.sv
imem_arbiter.sv
fetch_unit.sv
pipe_ctrl.sv
if_id_reg.sv
frontend_top.sv
frontend_props.sv
frontend_tb.sv

// File: run.sh
#!/bin/sh
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module frontend_tb -f sources.f -o frontend_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/frontend_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0
